/* verilog/slave_agent_macros.svh */
/*
 * slave agent configuration
 * widths of the fabric packet fields, the depths of the two internal
 * FIFOs and the depth of the registered read-return path
 */
`ifndef SLAVE_AGENT_MACROS_SVH
`define SLAVE_AGENT_MACROS_SVH

// byte address carried in the command packet and driven to the slave
`define SA_ADDR_W 16
// slave data bus width
`define SA_DATA_W 32
// one byteenable bit per byte lane of the data bus
`define SA_BE_W 4
// fabric source and destination id width
`define SA_ID_W 3

// pending-command FIFO, bounds the number of outstanding responses
`define SA_PEND_DEPTH 4
// read-data FIFO, kept equal to the pending depth so it can never overflow
`define SA_RDATA_DEPTH 4
// registered stages between the slave read data and the read-data FIFO
`define SA_RETURN_STAGES 2

`endif

/* verilog/slave_agent_pkg.sv */
/*
 * slave agent types
 * opcodes, response status and the packed structs that carry command
 * packets, pending-command entries, returned read data and response
 * packets between the blocks of the agent
 */
`include "slave_agent_macros.svh"

package slave_agent_pkg;

   // --------------------------------------------------
   // encodings
   // --------------------------------------------------

   // command opcode, the fourth code is unused and ignored by the agent
   typedef enum logic [1:0] {
      OP_READ         = 2'd0,
      OP_WRITE_POSTED = 2'd1,
      OP_WRITE_NP     = 2'd2
   } trans_op_e;

   // response status as returned by the slave and sent back to the fabric
   typedef enum logic [1:0] {
      RS_OKAY     = 2'd0,
      RS_RESERVED = 2'd1,
      RS_SLVERR   = 2'd2,
      RS_DECERR   = 2'd3
   } resp_status_e;

   // --------------------------------------------------
   // packets and entries
   // --------------------------------------------------

   // single-beat command packet from the fabric
   typedef struct packed {
      trans_op_e              op;
      logic [`SA_ADDR_W-1:0]  address;
      logic [`SA_BE_W-1:0]    byteenable;
      logic [`SA_DATA_W-1:0]  writedata;
      logic [`SA_ID_W-1:0]    src_id;
      logic [`SA_ID_W-1:0]    dest_id;
      logic                   debugaccess;
   } cmd_pkt_t;

   // what has to be remembered about a command until its response leaves
   typedef struct packed {
      trans_op_e              op;
      logic [`SA_BE_W-1:0]    byteenable;
      logic [`SA_ADDR_W-1:0]  address;
      logic [`SA_ID_W-1:0]    src_id;
      logic [`SA_ID_W-1:0]    dest_id;
      // response is made locally, no read data will come back for it
      logic                   synth;
   } pend_entry_t;

   // read data and status returned by the slave
   typedef struct packed {
      resp_status_e           status;
      logic [`SA_DATA_W-1:0]  data;
   } rdata_t;

   // response packet towards the fabric
   typedef struct packed {
      trans_op_e              op;
      logic [`SA_ADDR_W-1:0]  address;
      logic [`SA_BE_W-1:0]    byteenable;
      logic [`SA_ID_W-1:0]    src_id;
      logic [`SA_ID_W-1:0]    dest_id;
      resp_status_e           status;
      logic [`SA_DATA_W-1:0]  data;
   } resp_pkt_t;

   // command outputs of the memory-mapped slave port
   typedef struct packed {
      logic [`SA_ADDR_W-1:0]  address;
      logic [`SA_BE_W-1:0]    byteenable;
      logic                   read;
      logic                   write;
      logic [`SA_DATA_W-1:0]  writedata;
      logic                   debugaccess;
   } slave_cmd_t;

endpackage

/* verilog/cmd_translator.sv */
/*
 * command translator
 * turns a fabric command packet into slave-port strobes, suppresses
 * commands with no byte lane enabled and builds the pending-command
 * entry for every command that expects a response
 */
`timescale 1ns/1ps
`include "slave_agent_macros.svh"

module cmd_translator
   import slave_agent_pkg::*;
(
   input  logic        cp_valid,
   input  cmd_pkt_t    cp_data,
   output logic        cp_ready,
   output slave_cmd_t  m0,
   input  logic        m0_waitrequest,
   input  logic        pend_full,
   output logic        pend_push,
   output pend_entry_t pend_entry
);

   // clears the byte-offset bits so the slave only sees full-word addresses
   localparam logic [`SA_ADDR_W-1:0] WORD_MASK = ~(`SA_ADDR_W'(`SA_BE_W - 1));

   logic is_read;
   logic is_write;
   logic needs_resp;
   logic suppress;

   always_comb begin
      is_read    = (cp_data.op == OP_READ);
      is_write   = (cp_data.op == OP_WRITE_POSTED) || (cp_data.op == OP_WRITE_NP);
      needs_resp = is_read || (cp_data.op == OP_WRITE_NP);
      // nothing to do at the slave when no byte lane is enabled
      suppress   = ~|cp_data.byteenable;

      // a suppressed command never waits on the slave, every command waits
      // for room in the pending FIFO
      cp_ready = !pend_full && (!m0_waitrequest || suppress);

      m0.address     = cp_data.address & WORD_MASK;
      m0.byteenable  = cp_data.byteenable;
      m0.writedata   = cp_data.writedata;
      m0.debugaccess = cp_data.debugaccess;
      // strobes are held while waitrequest is high, so with the gating below
      // a slave transfer happens exactly on a cycle with cp_ready high
      m0.read  = cp_valid && is_read && !suppress && !pend_full;
      m0.write = cp_valid && is_write && !suppress && !pend_full;

      // posted writes leave no trace in the pending FIFO
      pend_push             = cp_valid && cp_ready && needs_resp;
      pend_entry.op         = cp_data.op;
      pend_entry.byteenable = cp_data.byteenable;
      pend_entry.address    = cp_data.address;
      pend_entry.src_id     = cp_data.src_id;
      pend_entry.dest_id    = cp_data.dest_id;
      // the slave has no write-response channel, so non-posted writes and
      // suppressed reads are answered by the agent itself
      pend_entry.synth      = (is_read && suppress) || (cp_data.op == OP_WRITE_NP);

      assert (!(m0.read && m0.write))
         else $error("slave read and write strobes asserted together");
   end

endmodule

/* verilog/read_return_pipe.sv */
/*
 * read return pipe
 * delays slave read data, status and valid by a fixed number of
 * register stages, matching the latency of a memory-block read path
 */
`timescale 1ns/1ps
`include "slave_agent_macros.svh"

module read_return_pipe
   import slave_agent_pkg::*;
#(
   parameter int STAGES = `SA_RETURN_STAGES
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   in_valid,
   input  rdata_t in_data,
   output logic   out_valid,
   output rdata_t out_data
);

   logic [STAGES-1:0] vld_q;
   rdata_t            data_q [STAGES];

   // only the valid bits need a known value after reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= in_valid;
         for (int i = 1; i < STAGES; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      data_q[0] <= in_data;
      for (int i = 1; i < STAGES; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   assign out_valid = vld_q[STAGES-1];
   assign out_data  = data_q[STAGES-1];

endmodule

/* verilog/agent_fifo.sv */
/*
 * agent FIFO
 * small synchronous circular buffer with a show-ahead head output,
 * used for both the pending commands and the returned read data
 */
`timescale 1ns/1ps

module agent_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] head_data,
   output logic             empty,
   output logic             full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= bump(wr_ptr);
         if (pop) rd_ptr <= bump(rd_ptr);
         // count moves only when exactly one side is active
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= push_data;
   end

   assign head_data = mem[rd_ptr];
   assign empty     = (count == '0);
   assign full      = (count == CNT_W'(DEPTH));

   no_overflow_a: assert property (@(posedge clk) disable iff (reset) !(push && full))
      else $error("push into a full FIFO");
   no_underflow_a: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
      else $error("pop from an empty FIFO");

endmodule

/* verilog/resp_control.sv */
/*
 * response control
 * pairs the oldest pending command with its read data, or answers it
 * locally, and holds the finished response packet in an output register
 * until the fabric takes it
 */
`timescale 1ns/1ps

module resp_control
   import slave_agent_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  pend_entry_t pend_head,
   input  logic        pend_empty,
   input  rdata_t      rdata_head,
   input  logic        rdata_empty,
   output logic        pend_pop,
   output logic        rdata_pop,
   output logic        rp_valid,
   output resp_pkt_t   rp_data,
   input  logic        rp_ready
);

   logic      resp_done;
   logic      load;
   resp_pkt_t next_pkt;

   // --------------------------------------------------
   // response completion
   // --------------------------------------------------

   // a synthesized response needs nothing more, a real read waits for data
   assign resp_done = !pend_empty && (pend_head.synth || !rdata_empty);

   // the output register takes a new packet when it is empty or being drained
   assign load      = resp_done && (!rp_valid || rp_ready);
   assign pend_pop  = load;
   // synthesized entries have no read-data entry to consume
   assign rdata_pop = load && !pend_head.synth;

   always_comb begin
      next_pkt.op         = pend_head.op;
      next_pkt.address    = pend_head.address;
      next_pkt.byteenable = pend_head.byteenable;
      // the response travels back, so source and destination swap places
      next_pkt.src_id     = pend_head.dest_id;
      next_pkt.dest_id    = pend_head.src_id;
      next_pkt.status     = pend_head.synth ? RS_OKAY : rdata_head.status;
      next_pkt.data       = pend_head.synth ? '0 : rdata_head.data;
   end

   // --------------------------------------------------
   // output stage
   // --------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rp_valid <= 1'b0;
      end else if (load) begin
         rp_valid <= 1'b1;
      end else if (rp_ready) begin
         rp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) rp_data <= next_pkt;
   end

   // a stalled response must not change or disappear before it is taken
   rp_hold_a: assert property (@(posedge clk) disable iff (reset)
      rp_valid && !rp_ready |=> rp_valid && $stable(rp_data))
      else $error("response packet changed under back-pressure");

endmodule

/* verilog/slave_agent_top.sv */
/*
 * memory-mapped slave agent
 * accepts single-beat fabric commands, drives the slave port and
 * returns one response packet per read and non-posted write, in order
 */
`timescale 1ns/1ps
`include "slave_agent_macros.svh"

module slave_agent_top
   import slave_agent_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cp_valid,
   input  cmd_pkt_t              cp_data,
   output logic                  cp_ready,
   output slave_cmd_t            m0,
   input  logic                  m0_waitrequest,
   input  logic [`SA_DATA_W-1:0] m0_readdata,
   input  logic                  m0_readdatavalid,
   input  resp_status_e          m0_response,
   output logic                  rp_valid,
   output resp_pkt_t             rp_data,
   input  logic                  rp_ready
);

   pend_entry_t pend_entry;
   pend_entry_t pend_head;
   logic        pend_push;
   logic        pend_pop;
   logic        pend_empty;
   logic        pend_full;

   rdata_t      ret_in;
   rdata_t      ret_data;
   rdata_t      rdata_head;
   logic        ret_valid;
   logic        rdata_pop;
   logic        rdata_empty;

   // --------------------------------------------------
   // command side
   // --------------------------------------------------

   cmd_translator cmd_translator_i (
      .cp_valid       (cp_valid),
      .cp_data        (cp_data),
      .cp_ready       (cp_ready),
      .m0             (m0),
      .m0_waitrequest (m0_waitrequest),
      .pend_full      (pend_full),
      .pend_push      (pend_push),
      .pend_entry     (pend_entry)
   );

   agent_fifo #(.WIDTH($bits(pend_entry_t)), .DEPTH(`SA_PEND_DEPTH)) pend_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (pend_push),
      .push_data (pend_entry),
      .pop       (pend_pop),
      .head_data (pend_head),
      .empty     (pend_empty),
      .full      (pend_full)
   );

   // --------------------------------------------------
   // read return and response side
   // --------------------------------------------------

   assign ret_in = '{status: m0_response, data: m0_readdata};

   read_return_pipe #(.STAGES(`SA_RETURN_STAGES)) read_return_pipe_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (m0_readdatavalid),
      .in_data   (ret_in),
      .out_valid (ret_valid),
      .out_data  (ret_data)
   );

   // never fills, since every entry here belongs to a pending read
   agent_fifo #(.WIDTH($bits(rdata_t)), .DEPTH(`SA_RDATA_DEPTH)) rdata_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (ret_valid),
      .push_data (ret_data),
      .pop       (rdata_pop),
      .head_data (rdata_head),
      .empty     (rdata_empty),
      .full      ()
   );

   resp_control resp_control_i (
      .clk         (clk),
      .reset       (reset),
      .pend_head   (pend_head),
      .pend_empty  (pend_empty),
      .rdata_head  (rdata_head),
      .rdata_empty (rdata_empty),
      .pend_pop    (pend_pop),
      .rdata_pop   (rdata_pop),
      .rp_valid    (rp_valid),
      .rp_data     (rp_data),
      .rp_ready    (rp_ready)
   );

endmodule

/* bench/slave_agent_checker.sv */
/*
 * slave agent checker
 * keeps a shadow of the slave memory and a queue of expected responses,
 * and compares slave-port and response traffic at every transfer
 */
`timescale 1ns/1ps
`include "slave_agent_macros.svh"

module slave_agent_checker
   import slave_agent_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cp_valid,
   input  logic                  cp_ready,
   input  cmd_pkt_t              cp_data,
   input  slave_cmd_t            m0,
   input  logic                  m0_waitrequest,
   input  logic                  rp_valid,
   input  logic                  rp_ready,
   input  resp_pkt_t             rp_data,
   input  logic [`SA_ADDR_W-1:0] exp_addr,
   input  logic                  exp_strobe,
   output int                    mismatch_errors,
   output int                    other_errors,
   output int                    outstanding
);

   logic [`SA_DATA_W-1:0] shadow [64];
   resp_pkt_t             expected_q [$];
   resp_pkt_t             held_pkt;
   logic                  held_valid;

   function automatic logic [`SA_DATA_W-1:0] fill_word(input int idx);
      return 32'h9e3779b9 * (idx + 1);
   endfunction

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, expected, actual);
         mismatch_errors++;
      end
   endtask

   initial begin
      mismatch_errors = 0;
      other_errors    = 0;
      outstanding     = 0;
      held_valid      = 1'b0;
      for (int i = 0; i < 64; i++) shadow[i] = fill_word(i);
   end

   // --------------------------------------------------
   // command and response traffic sampled on every rising clock edge
   // --------------------------------------------------

   always @(posedge clk) begin : watch
      logic       accepted;
      logic       strobe;
      logic [5:0] idx;
      int         pend_used;
      resp_pkt_t  exp_pkt;
      accepted = cp_valid && cp_ready;
      strobe   = m0.read || m0.write;
      idx      = cp_data.address[7:2];
      if (reset) begin
         if (rp_valid || strobe) begin
            $display("rp_valid or a slave strobe is high during reset at %0t", $time);
            other_errors++;
         end
         held_valid = 1'b0;
      end else begin
         // occupancy of the pending FIFO is what is owed minus the output register
         pend_used = expected_q.size() - (rp_valid ? 1 : 0);
         if (pend_used >= `SA_PEND_DEPTH && cp_ready) begin
            $display("cp_ready is high at %0t although the pending FIFO is full", $time);
            other_errors++;
         end
         if ((strobe && !m0_waitrequest) != (accepted && cp_data.byteenable != '0)) begin
            $display("slave transfer at %0t does not line up with command acceptance", $time);
            other_errors++;
         end
         if (accepted) begin
            compare_value("m0 strobe", 64'(exp_strobe), 64'(strobe));
            if (strobe) begin
               compare_value("m0.address", 64'(exp_addr), 64'(m0.address));
               compare_value("m0.byteenable", 64'(cp_data.byteenable), 64'(m0.byteenable));
               compare_value("m0.read", 64'(cp_data.op == OP_READ), 64'(m0.read));
               compare_value("m0.write",
                             64'(cp_data.op == OP_WRITE_POSTED || cp_data.op == OP_WRITE_NP),
                             64'(m0.write));
               compare_value("m0.debugaccess", 64'(cp_data.debugaccess),
                             64'(m0.debugaccess));
               if (cp_data.op != OP_READ) begin
                  compare_value("m0.writedata", 64'(cp_data.writedata), 64'(m0.writedata));
               end
            end
            // writes with at least one lane land in the shadow memory
            if (cp_data.op != OP_READ && cp_data.byteenable != '0) begin
               for (int b = 0; b < `SA_BE_W; b++) begin
                  if (cp_data.byteenable[b]) shadow[idx][8*b +: 8] = cp_data.writedata[8*b +: 8];
               end
            end
            if (cp_data.op != OP_WRITE_POSTED) begin
               exp_pkt.op         = cp_data.op;
               exp_pkt.address    = cp_data.address;
               exp_pkt.byteenable = cp_data.byteenable;
               exp_pkt.src_id     = cp_data.dest_id;
               exp_pkt.dest_id    = cp_data.src_id;
               if (cp_data.op == OP_READ && cp_data.byteenable != '0) begin
                  exp_pkt.status = cp_data.address[15] ? RS_SLVERR : RS_OKAY;
                  exp_pkt.data   = shadow[idx];
               end else begin
                  exp_pkt.status = RS_OKAY;
                  exp_pkt.data   = '0;
               end
               expected_q.push_back(exp_pkt);
            end
         end
         // a stalled response has to come back unchanged
         if (held_valid) begin
            if (!rp_valid) begin
               $display("rp_valid dropped at %0t before the response was taken", $time);
               other_errors++;
            end else begin
               compare_value("rp_data held", 64'(held_pkt), 64'(rp_data));
            end
         end
         if (rp_valid && rp_ready) begin
            if (expected_q.size() == 0) begin
               $display("a response arrived at %0t with no command waiting for it", $time);
               other_errors++;
            end else begin
               exp_pkt = expected_q.pop_front();
               compare_value("rp_data.op", 64'(exp_pkt.op), 64'(rp_data.op));
               compare_value("rp_data.address", 64'(exp_pkt.address), 64'(rp_data.address));
               compare_value("rp_data.byteenable", 64'(exp_pkt.byteenable),
                             64'(rp_data.byteenable));
               compare_value("rp_data.src_id", 64'(exp_pkt.src_id), 64'(rp_data.src_id));
               compare_value("rp_data.dest_id", 64'(exp_pkt.dest_id), 64'(rp_data.dest_id));
               compare_value("rp_data.status", 64'(exp_pkt.status), 64'(rp_data.status));
               compare_value("rp_data.data", 64'(exp_pkt.data), 64'(rp_data.data));
            end
         end
         held_valid = rp_valid && !rp_ready;
         held_pkt   = rp_data;
      end
      outstanding = expected_q.size();
   end

endmodule

/* bench/tb_slave_agent.sv */
/*
 * testbench for the memory-mapped slave agent
 * replays command patterns from a file, models the slave memory behind
 * the m0 port and throttles the response channel
 */
`timescale 1ns/1ps
`include "slave_agent_macros.svh"

module tb_slave_agent
   import slave_agent_pkg::*;
();

   localparam int MAX_ROWS = 64;

   logic                  clk;
   logic                  reset;
   logic                  cp_valid;
   cmd_pkt_t              cp_data;
   logic                  cp_ready;
   slave_cmd_t            m0;
   logic                  m0_waitrequest;
   logic [`SA_DATA_W-1:0] m0_readdata;
   logic                  m0_readdatavalid;
   resp_status_e          m0_response;
   logic                  rp_valid;
   resp_pkt_t             rp_data;
   logic                  rp_ready;
   logic [`SA_ADDR_W-1:0] exp_addr;
   logic                  exp_strobe;

   logic [95:0]           patterns [MAX_ROWS];
   logic [`SA_DATA_W-1:0] slave_mem [64];
   int                    pat_count = 0;
   logic                  patterns_loaded = 1'b0;
   integer                seed = 7;
   int                    rp_stall_q [$];
   int                    mismatch_errors;
   int                    other_errors;
   int                    outstanding;

   // same spread of values as the checker's shadow memory starts from
   function automatic logic [`SA_DATA_W-1:0] fill_word(input int idx);
      return 32'h9e3779b9 * (idx + 1);
   endfunction

   initial clk = 1'b0;
   always #10 clk = ~clk;

   slave_agent_top slave_agent_top_i (
      .clk (clk), .reset (reset),
      .cp_valid (cp_valid), .cp_data (cp_data), .cp_ready (cp_ready),
      .m0 (m0), .m0_waitrequest (m0_waitrequest), .m0_readdata (m0_readdata),
      .m0_readdatavalid (m0_readdatavalid), .m0_response (m0_response),
      .rp_valid (rp_valid), .rp_data (rp_data), .rp_ready (rp_ready)
   );

   slave_agent_checker checker_i (
      .clk (clk), .reset (reset),
      .cp_valid (cp_valid), .cp_ready (cp_ready), .cp_data (cp_data),
      .m0 (m0), .m0_waitrequest (m0_waitrequest),
      .rp_valid (rp_valid), .rp_ready (rp_ready), .rp_data (rp_data),
      .exp_addr (exp_addr), .exp_strobe (exp_strobe),
      .mismatch_errors (mismatch_errors), .other_errors (other_errors),
      .outstanding (outstanding)
   );

   // --------------------------------------------------
   // slave model
   // --------------------------------------------------

   // a transfer happens on an edge with a strobe and no waitrequest, read
   // data comes back one cycle later
   always @(posedge clk) begin : slave_model
      logic       read_go;
      logic       slverr;
      logic [5:0] idx;
      read_go = m0.read && !m0_waitrequest;
      slverr  = m0.address[15];
      idx     = m0.address[7:2];
      if (m0.write && !m0_waitrequest) begin
         for (int b = 0; b < `SA_BE_W; b++) begin
            if (m0.byteenable[b]) slave_mem[idx][8*b +: 8] = m0.writedata[8*b +: 8];
         end
      end
      #1;
      m0_readdatavalid = read_go;
      m0_readdata      = read_go ? slave_mem[idx] : '0;
      m0_response      = (read_go && slverr) ? RS_SLVERR : RS_OKAY;
   end

   // --------------------------------------------------
   // command driver
   // --------------------------------------------------

   // row nibbles from the top: op, address, byteenable, writedata, src, dest,
   // debugaccess, expected slave address, expected strobe, wait stall, rp stall
   task automatic issue_row(input logic [95:0] row);
      logic accepted;
      int   cycles;
      int   wstall;
      cp_data.op          = trans_op_e'(row[93:92]);
      cp_data.address     = row[91:76];
      cp_data.byteenable  = row[75:72];
      cp_data.writedata   = row[71:40];
      cp_data.src_id      = row[38:36];
      cp_data.dest_id     = row[34:32];
      cp_data.debugaccess = row[28];
      exp_addr            = row[27:12];
      exp_strobe          = row[8];
      wstall              = int'(row[7:4]);
      if (cp_data.op != OP_WRITE_POSTED) rp_stall_q.push_back(int'(row[3:0]));
      cp_valid       = 1'b1;
      m0_waitrequest = (wstall != 0);
      cycles         = 0;
      // cp_ready settles after the drive delay, so it is sampled mid-cycle
      do begin
         @(negedge clk);
         accepted = cp_ready;
         @(posedge clk);
         #1;
         cycles++;
         if (cycles >= wstall) m0_waitrequest = 1'b0;
      end while (!accepted);
      cp_valid       = 1'b0;
      m0_waitrequest = 1'b0;
   endtask

   // response consumer, holds rp_ready low for the row's stall plus a random gap
   initial begin : responder
      int gap;
      rp_ready = 1'b0;
      forever begin
         @(negedge clk);
         if (rp_valid) begin
            gap = (rp_stall_q.size() != 0) ? rp_stall_q.pop_front() : 0;
            gap = gap + int'({$random(seed)} % 3);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            #1 rp_ready = 1'b1;
            @(posedge clk);
            #1 rp_ready = 1'b0;
         end
      end
   end

   initial begin : main
      for (int i = 0; i < MAX_ROWS; i++) patterns[i] = '1;
      $readmemh("bench/slave_agent_patterns.txt", patterns);
      while (pat_count < MAX_ROWS && patterns[pat_count] != '1) pat_count++;
      patterns_loaded = 1'b1;
      for (int i = 0; i < 64; i++) slave_mem[i] = fill_word(i);
      reset            = 1'b1;
      cp_valid         = 1'b0;
      cp_data          = '0;
      m0_waitrequest   = 1'b0;
      m0_readdata      = '0;
      m0_readdatavalid = 1'b0;
      m0_response      = RS_OKAY;
      exp_addr         = '0;
      exp_strobe       = 1'b0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      for (int i = 0; i < pat_count; i++) issue_row(patterns[i]);
      // every response owed must drain before the verdict
      while (outstanding != 0) @(negedge clk);
      repeat (5) @(negedge clk);
      $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      wait (patterns_loaded);
      repeat (pat_count * 40 + 200) @(posedge clk);
      $display("timeout after %0d cycles with %0d responses still missing",
               pat_count * 40 + 200, outstanding);
      $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* bench/slave_agent_patterns.txt */
// op_address_be_writedata_src_dest_debug_expaddr_strobe_waitstall_rpstall
// op 0 read, 1 posted write, 2 non-posted write; stalls in clock cycles
2_0010_f_11223344_1_2_0_0010_1_0_0
0_0012_f_00000000_1_2_0_0010_1_0_1
1_0021_3_aabbccdd_3_4_0_0020_1_2_0
0_0020_f_00000000_3_4_0_0020_1_3_0
0_8024_f_00000000_5_6_0_8024_1_0_2
0_0030_0_00000000_2_1_0_0030_0_0_0
1_0040_0_deadbeef_2_1_0_0040_0_0_0
2_0043_0_deadbeef_4_7_0_0040_0_4_0
2_0044_c_55667788_0_5_1_0044_1_1_0
0_0046_f_00000000_6_1_1_0044_1_0_c
0_0010_f_00000000_7_0_0_0010_1_0_0
2_00fc_1_000000ee_1_3_0_00fc_1_0_0
0_00fd_2_00000000_2_3_0_00fc_1_0_0
0_8000_f_00000000_4_2_0_8000_1_0_1
1_0004_f_cafef00d_5_5_0_0004_1_0_0
0_0004_f_00000000_5_5_0_0004_1_1_5
2_0008_6_12345678_6_2_0_0008_1_2_0
0_000b_f_00000000_6_2_0_0008_1_0_0
0_0039_8_00000000_1_1_0_0038_1_1_3
0_00fc_f_00000000_0_7_0_00fc_1_0_0
2_8043_f_0badf00d_3_6_0_8040_1_0_0
0_8043_1_00000000_6_3_0_8040_1_0_0

/* src.f */
+incdir+verilog
verilog/slave_agent_pkg.sv
verilog/cmd_translator.sv
verilog/read_return_pipe.sv
verilog/agent_fifo.sv
verilog/resp_control.sv
verilog/slave_agent_top.sv
bench/slave_agent_checker.sv
bench/tb_slave_agent.sv

/* Makefile */
# Verilator build and run of the slave agent testbench

VERILATOR ?= verilator
TOP       ?= tb_slave_agent
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
